/* tb/pwo_vectors.txt */
# T op acc a_base b_base c_base   (op 0 mul, 1 add, 2 sub, 3 none; bases in hex)
# S word lane a b c expected      (a, b, c, expected in hex; used by the next T line)
S 0 0 000002 000003 000000 000006
S 1 2 7fe000 7fe000 000000 000001
S 5 3 7fe000 000002 000000 7fdfff
T 0 0 0000 0040 0080
S 7 1 7fe000 000001 000001 000000
S 9 0 000100 000100 000005 010005
T 0 1 0005 1000 2003
S 2 0 7fe000 000005 000000 000004
S 3 1 400000 3fe001 000000 000000
S 4 2 000001 000002 000000 000003
T 1 0 0010 0020 0030
S 0 3 000003 000005 000000 7fdfff
S 1 0 000000 7fe000 000000 000001
S 2 1 000009 000004 000000 000005
S 6 2 123456 123456 000000 000000
T 2 0 0040 0041 00c0
T 3 0 0000 0000 0000
S 63 3 001000 001000 000000 003ffe
T 0 0 003f 0000 0007

/* all.f */
logic/ntt_params_pkg.sv
logic/ntt_types_pkg.sv
logic/pwo_lane_if.sv
logic/pwo_ctrl.sv
logic/pwo_operand_split.sv
logic/pwo_mod_lane.sv
logic/pwo_result_pack.sv
logic/ntt_pwo_top.sv
tb/ntt_pwo_chk.sv
tb/ntt_pwo_tb.sv

/* tb/ntt_pwo_tb.sv */
// Testbench for the pointwise multiply, add and subtract datapath.
// Test commands and spot checks come from tb/pwo_vectors.txt. Three
// memory models answer the read strobes, and every write is compared
// with a reference model built from the memory contents before a run.

module ntt_pwo_tb;

    localparam int DLY = 10;
    localparam int W = ntt_params_pkg::POLY_WORDS;
    localparam int L = ntt_params_pkg::LANES;
    localparam longint unsigned Q = ntt_params_pkg::NTT_Q;

    logic                     clk;
    logic                     reset_n;
    logic                     zeroize_i;
    logic                     enable_i;
    ntt_types_pkg::pwo_op_t   mode_i;
    logic                     accumulate_i;
    ntt_types_pkg::mem_addr_t a_base_i, b_base_i, c_base_i;
    logic                     a_rd_en_o, b_rd_en_o, c_rd_en_o;
    ntt_types_pkg::mem_addr_t a_rd_addr_o, b_rd_addr_o, c_rd_addr_o;
    ntt_types_pkg::mem_word_t a_rd_data_i, b_rd_data_i, c_rd_data_i;
    logic                     wr_en_o;
    ntt_types_pkg::mem_addr_t wr_addr_o;
    ntt_types_pkg::mem_word_t wr_data_o;
    logic                     busy_o;
    logic                     done_o;

    // Memory models and the expected result words
    ntt_types_pkg::mem_word_t mem_a [W];
    ntt_types_pkg::mem_word_t mem_b [W];
    ntt_types_pkg::mem_word_t mem_c [W];
    ntt_types_pkg::mem_word_t exp_w [W];
    ntt_types_pkg::mem_addr_t cur_ab, cur_bb, cur_cb;

    // Vector file contents, S lines tagged with their test index
    int t_op[$], t_acc[$], t_ab[$], t_bb[$], t_cb[$];
    int s_test[$], s_word[$], s_lane[$], s_a[$], s_b[$], s_c[$], s_exp[$];

    int seed = 32'hc0c4;
    int cycles = 0;
    int limit = 1000;
    int wr_seen, done_seen, c_rd_seen, rd_seen;
    logic last_wr_prev = 1'b0;

    ntt_pwo_top UUT (.*);

    bind ntt_pwo_top ntt_pwo_chk u_chk (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input ntt_types_pkg::mem_addr_t addr,
                              input ntt_types_pkg::mem_word_t data);
        ntt_types_pkg::mem_addr_t exp_addr;
        exp_addr = cur_cb + ntt_types_pkg::mem_addr_t'(wr_seen);
        if (wr_seen >= W || addr !== exp_addr)
            abort_run($sformatf("MISMATCH at %0t: write %0d went to address %h, expected %h",
                                $time, wr_seen, addr, exp_addr));
        else if (data !== exp_w[wr_seen])
            abort_run($sformatf("MISMATCH at %0t: word %0d is %h, expected %h",
                                $time, wr_seen, data, exp_w[wr_seen]));
    endtask

    task automatic check_addr(input ntt_types_pkg::mem_addr_t got,
                              input ntt_types_pkg::mem_addr_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_coeff(input ntt_types_pkg::coeff_t got, input ntt_types_pkg::coeff_t exp,
                               input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    function automatic ntt_types_pkg::coeff_t random_coeff();
        return ntt_types_pkg::coeff_t'({$random(seed)} % Q);
    endfunction

    // Memories answer a read strobe one cycle later, word k at base plus k
    always @(posedge clk) begin
        if (a_rd_en_o) begin
            check_addr(a_rd_addr_o, cur_ab + ntt_types_pkg::mem_addr_t'(rd_seen),
                       "operand a read address");
            a_rd_data_i <= #DLY mem_a[a_rd_addr_o % W];
        end
        if (b_rd_en_o) begin
            check_addr(b_rd_addr_o, cur_bb + ntt_types_pkg::mem_addr_t'(rd_seen),
                       "operand b read address");
            b_rd_data_i <= #DLY mem_b[b_rd_addr_o % W];
        end
        if (c_rd_en_o) begin
            check_addr(c_rd_addr_o, cur_cb + ntt_types_pkg::mem_addr_t'(rd_seen),
                       "destination read address");
            c_rd_data_i <= #DLY mem_c[c_rd_addr_o % W];
        end
        if (a_rd_en_o) rd_seen++;
    end

    // Write port, event counters and timeout
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) abort_run("Timeout: the tests did not finish within the cycle limit");
        if (UUT.u_chk.fail_count != 0) abort_run("An assertion on the control outputs failed");
        // Done follows the write of the last word by one cycle
        if (reset_n) check_flag(done_o, last_wr_prev, "done pulse");
        last_wr_prev = wr_en_o && wr_seen == W - 1;
        if (wr_en_o) begin
            check_word(wr_addr_o, wr_data_o);
            mem_c[wr_addr_o % W] <= wr_data_o;
            wr_seen++;
        end
        if (done_o) done_seen++;
        if (c_rd_en_o) c_rd_seen++;
    end

    //======================================================================
    // Memory setup and reference model
    //======================================================================
    task automatic prepare_test(input int ti, input ntt_types_pkg::pwo_op_t op, input logic acc,
                                input ntt_types_pkg::mem_addr_t ab, bb, cb);
        longint unsigned a, b, c, r;
        for (int k = 0; k < W; k++) begin
            for (int l = 0; l < L; l++) begin
                mem_a[k][l] = random_coeff();
                mem_b[k][l] = random_coeff();
                mem_c[k][l] = random_coeff();
            end
        end
        foreach (s_test[i]) begin
            if (s_test[i] == ti) begin
                mem_a[(ab + s_word[i]) % W][s_lane[i]] = s_a[i];
                mem_b[(bb + s_word[i]) % W][s_lane[i]] = s_b[i];
                mem_c[(cb + s_word[i]) % W][s_lane[i]] = s_c[i];
            end
        end
        for (int k = 0; k < W; k++) begin
            for (int l = 0; l < L; l++) begin
                a = mem_a[(ab + k) % W][l];
                b = mem_b[(bb + k) % W][l];
                c = (acc && op == ntt_types_pkg::PWO_MUL) ? mem_c[(cb + k) % W][l] : 0;
                case (op)
                    ntt_types_pkg::PWO_ADD: r = (a + b) % Q;
                    ntt_types_pkg::PWO_SUB: r = (a >= b) ? a - b : a + Q - b;
                    default:                r = (a * b + c) % Q;
                endcase
                exp_w[k][l] = ntt_params_pkg::SLOT_W'(r);
            end
        end
    endtask

    // Called and returns a short delay after a rising edge
    task automatic start_run(input ntt_types_pkg::pwo_op_t op, input logic acc,
                             input ntt_types_pkg::mem_addr_t ab, bb, cb);
        cur_ab = ab;
        cur_bb = bb;
        cur_cb = cb;
        wr_seen = 0;
        done_seen = 0;
        c_rd_seen = 0;
        rd_seen = 0;
        mode_i = op;
        accumulate_i = acc;
        a_base_i = ab;
        b_base_i = bb;
        c_base_i = cb;
        enable_i = 1'b1;
        @(posedge clk);
        #DLY;
        enable_i = 1'b0;
    endtask

    task automatic run_test(input int ti, input ntt_types_pkg::pwo_op_t op, input logic acc,
                            input ntt_types_pkg::mem_addr_t ab, bb, cb);
        prepare_test(ti, op, acc, ab, bb, cb);
        start_run(op, acc, ab, bb, cb);
        if (op == ntt_types_pkg::PWO_NONE) begin
            // Long enough for a first write to show up
            repeat (6) @(posedge clk);
            #DLY;
            check_flag(busy_o, 1'b0, "busy after a request with no operation");
            check_count(wr_seen, 0, "writes after a request with no operation");
        end else begin
            check_flag(busy_o, 1'b1, "busy after start");
            // Second request during the run
            repeat (8) @(posedge clk);
            #DLY;
            mode_i = ntt_types_pkg::PWO_ADD;
            enable_i = 1'b1;
            @(posedge clk);
            #DLY;
            enable_i = 1'b0;
            mode_i = op;
            while (done_seen == 0) begin
                @(posedge clk);
                #DLY;
            end
            check_flag(busy_o, 1'b0, "busy after done");
            check_count(wr_seen, W, "writes in one run");
            check_count(rd_seen, W, "operand reads");
            check_count(c_rd_seen, (acc && op == ntt_types_pkg::PWO_MUL) ? W : 0,
                        "destination reads");
            repeat (3) @(posedge clk);
            #DLY;
            check_count(done_seen, 1, "done pulses");
            check_count(wr_seen, W, "writes after done");
            foreach (s_test[i]) begin
                if (s_test[i] == ti)
                    check_coeff(ntt_types_pkg::coeff_t'(mem_c[(cb + s_word[i]) % W][s_lane[i]]),
                                ntt_types_pkg::coeff_t'(s_exp[i]),
                                $sformatf("spot word %0d lane %0d", s_word[i], s_lane[i]));
            end
        end
    endtask

    //======================================================================
    // Aborted run followed by a fresh one
    //======================================================================
    task automatic zeroize_test();
        int n;
        prepare_test(-1, ntt_types_pkg::PWO_MUL, 1'b0, 15'h0100, 15'h0200, 15'h0300);
        start_run(ntt_types_pkg::PWO_MUL, 1'b0, 15'h0100, 15'h0200, 15'h0300);
        repeat (20) @(posedge clk);
        #DLY;
        zeroize_i = 1'b1;
        @(posedge clk);
        #DLY;
        zeroize_i = 1'b0;
        check_flag(busy_o, 1'b0, "busy after zeroize");
        check_flag(a_rd_en_o | b_rd_en_o | c_rd_en_o, 1'b0, "read enables after zeroize");
        check_flag(wr_en_o, 1'b0, "write enable after zeroize");
        n = wr_seen;
        repeat (10) @(posedge clk);
        #DLY;
        check_count(wr_seen, n, "writes after zeroize");
        check_count(done_seen, 0, "done pulses after zeroize");
        run_test(-1, ntt_types_pkg::PWO_MUL, 1'b0, 15'h0100, 15'h0200, 15'h0300);
    endtask

    initial begin
        int fd;
        byte kind;
        string line;
        int op, acc, ab, bb, cb, w, l, a, b, c, e;
        reset_n = 1'b0;
        zeroize_i = 1'b0;
        enable_i = 1'b0;
        mode_i = ntt_types_pkg::PWO_NONE;
        accumulate_i = 1'b0;
        a_base_i = '0;
        b_base_i = '0;
        c_base_i = '0;
        a_rd_data_i = '0;
        b_rd_data_i = '0;
        c_rd_data_i = '0;
        fd = $fopen("tb/pwo_vectors.txt", "r");
        if (fd == 0) abort_run("Could not open the vector file tb/pwo_vectors.txt");
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                void'($fgets(line, fd));
            end else if (kind == "T" && $fscanf(fd, "%d %d %h %h %h", op, acc, ab, bb, cb) == 5) begin
                t_op.push_back(op);
                t_acc.push_back(acc);
                t_ab.push_back(ab);
                t_bb.push_back(bb);
                t_cb.push_back(cb);
            end else if (kind == "S" && $fscanf(fd, "%d %d %h %h %h %h", w, l, a, b, c, e) == 6) begin
                s_test.push_back(t_op.size());
                s_word.push_back(w);
                s_lane.push_back(l);
                s_a.push_back(a);
                s_b.push_back(b);
                s_c.push_back(c);
                s_exp.push_back(e);
            end else begin
                abort_run("The vector file holds a line that cannot be read");
            end
        end
        $fclose(fd);
        // Zeroize test counts as two runs
        limit = (t_op.size() + 2) * 80 + 50;
        repeat (2) @(posedge clk);
        #DLY;
        reset_n = 1'b1;
        @(posedge clk);
        #DLY;
        foreach (t_op[i])
            run_test(i, ntt_types_pkg::pwo_op_t'(t_op[i]), t_acc[i] != 0,
                     ntt_types_pkg::mem_addr_t'(t_ab[i]), ntt_types_pkg::mem_addr_t'(t_bb[i]),
                     ntt_types_pkg::mem_addr_t'(t_cb[i]));
        zeroize_test();
        if (UUT.u_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb/ntt_pwo_chk.sv */
// Concurrent checks on the control outputs of the pointwise top level.
// Bound into the top level from the testbench, one instance per DUT.

module ntt_pwo_chk (
    input logic clk,
    input logic reset_n,
    input logic busy_o,
    input logic done_o,
    input logic wr_en_o,
    input logic a_rd_en_o,
    input logic b_rd_en_o,
    input logic c_rd_en_o
);

    // Failures so far, watched by the testbench monitor
    int unsigned fail_count = 0;

    // Writes only inside a run
    a_wr_in_run: assert property (@(posedge clk) disable iff (!reset_n) wr_en_o |-> busy_o)
        else begin
            fail_count++;
            $error("write strobe seen while not busy");
        end

    // Done closes a run, busy falls in the same cycle
    a_done_after_busy: assert property (
        @(posedge clk) disable iff (!reset_n) done_o |-> $past(busy_o) && !busy_o
    ) else begin
        fail_count++;
        $error("done pulse without a run ending in the previous cycle");
    end

    a_rd_in_run: assert property (
        @(posedge clk) disable iff (!reset_n) (a_rd_en_o | b_rd_en_o | c_rd_en_o) |-> busy_o
    ) else begin
        fail_count++;
        $error("read enable seen while not busy");
    end

endmodule

/* logic/ntt_pwo_top.sv */
// Top level of the pointwise multiply, add and subtract datapath.
// Connects the controller, operand feeder, four modular lanes and
// the result drainer. Read latency of all memories is one cycle.

module ntt_pwo_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      enable_i,
    input  ntt_types_pkg::pwo_op_t    mode_i,
    input  logic                      accumulate_i,
    input  ntt_types_pkg::mem_addr_t  a_base_i,
    input  ntt_types_pkg::mem_addr_t  b_base_i,
    input  ntt_types_pkg::mem_addr_t  c_base_i,
    output logic                      a_rd_en_o,
    output logic                      b_rd_en_o,
    output logic                      c_rd_en_o,
    output ntt_types_pkg::mem_addr_t  a_rd_addr_o,
    output ntt_types_pkg::mem_addr_t  b_rd_addr_o,
    output ntt_types_pkg::mem_addr_t  c_rd_addr_o,
    input  ntt_types_pkg::mem_word_t  a_rd_data_i,
    input  ntt_types_pkg::mem_word_t  b_rd_data_i,
    input  ntt_types_pkg::mem_word_t  c_rd_data_i,
    output logic                      wr_en_o,
    output ntt_types_pkg::mem_addr_t  wr_addr_o,
    output ntt_types_pkg::mem_word_t  wr_data_o,
    output logic                      busy_o,
    output logic                      done_o
);

    logic                   data_valid;
    ntt_types_pkg::pwo_op_t op;
    logic                   acc;
    logic                   last_write;

    pwo_lane_if lane_if [ntt_params_pkg::LANES] ();

    pwo_ctrl u_ctrl (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .enable_i(enable_i), .mode_i(mode_i), .accumulate_i(accumulate_i),
        .a_base_i(a_base_i), .b_base_i(b_base_i), .c_base_i(c_base_i),
        .a_rd_en_o(a_rd_en_o), .b_rd_en_o(b_rd_en_o), .c_rd_en_o(c_rd_en_o),
        .a_rd_addr_o(a_rd_addr_o), .b_rd_addr_o(b_rd_addr_o), .c_rd_addr_o(c_rd_addr_o),
        .data_valid_o(data_valid), .op_o(op), .acc_o(acc),
        .last_write_i(last_write), .busy_o(busy_o), .done_o(done_o)
    );

    pwo_operand_split u_split (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .data_valid_i(data_valid), .op_i(op), .acc_i(acc),
        .a_word_i(a_rd_data_i), .b_word_i(b_rd_data_i), .c_word_i(c_rd_data_i),
        .lanes(lane_if)
    );

    // Four identical coefficient lanes
    for (genvar g = 0; g < ntt_params_pkg::LANES; g++) begin : g_lane
        pwo_mod_lane u_lane (
            .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
            .lane(lane_if[g])
        );
    end

    pwo_result_pack u_pack (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .c_base_i(c_base_i), .lanes(lane_if),
        .wr_en_o(wr_en_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o),
        .last_write_o(last_write)
    );

endmodule

/* logic/pwo_result_pack.sv */
// Result drainer for the lane array.
// Packs the four lane results into one padded word and drives the
// write port directly, with its own word counter for the address.

module pwo_result_pack (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  ntt_types_pkg::mem_addr_t  c_base_i,
    pwo_lane_if.drain                 lanes [ntt_params_pkg::LANES],
    output logic                      wr_en_o,
    output ntt_types_pkg::mem_addr_t  wr_addr_o,
    output ntt_types_pkg::mem_word_t  wr_data_o,
    output logic                      last_write_o
);

    logic [$clog2(ntt_params_pkg::POLY_WORDS)-1:0] wr_cnt;

    // All lanes run in lockstep, lane 0 stands for the word
    assign wr_en_o      = lanes[0].res_valid;
    assign wr_addr_o    = c_base_i + ntt_types_pkg::mem_addr_t'(wr_cnt);
    assign last_write_o = wr_en_o
                        & (wr_cnt == ($bits(wr_cnt))'(ntt_params_pkg::POLY_WORDS - 1));

    for (genvar g = 0; g < ntt_params_pkg::LANES; g++) begin : g_slot
        assign wr_data_o[g] = ntt_params_pkg::SLOT_W'(lanes[g].res);
    end

    // Word counter, back to zero after the last word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt <= '0;
        end else if (zeroize_i) begin
            wr_cnt <= '0;
        end else if (wr_en_o) begin
            if (last_write_o) begin
                wr_cnt <= '0;
            end else begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/pwo_mod_lane.sv */
// One modular lane of the pointwise datapath.
// Stage 1 forms the unreduced value, stage 2 reduces it mod q.
// Fully pipelined, accepts one coefficient per cycle.

module pwo_mod_lane (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    pwo_lane_if.lane   lane
);

    logic [ntt_params_pkg::PRODUCT_W-1:0] full_d;
    logic [ntt_params_pkg::PRODUCT_W-1:0] full_q;
    logic [ntt_params_pkg::PRODUCT_W-1:0] rem_d;
    logic                                 s1_valid;

    //======================================================================
    // Stage 1: unreduced value
    //======================================================================
    always_comb begin
        unique case (lane.op)
            ntt_types_pkg::PWO_MUL: begin
                full_d = ntt_params_pkg::PRODUCT_W'(lane.a) * ntt_params_pkg::PRODUCT_W'(lane.b)
                       + ntt_params_pkg::PRODUCT_W'(lane.c);
            end
            ntt_types_pkg::PWO_ADD: begin
                full_d = ntt_params_pkg::PRODUCT_W'(lane.a) + ntt_params_pkg::PRODUCT_W'(lane.b);
            end
            // Adding q first keeps the difference non-negative
            ntt_types_pkg::PWO_SUB: begin
                full_d = ntt_params_pkg::PRODUCT_W'(lane.a)
                       + ntt_params_pkg::PRODUCT_W'(ntt_params_pkg::NTT_Q)
                       - ntt_params_pkg::PRODUCT_W'(lane.b);
            end
            default: begin
                full_d = '0;
            end
        endcase
    end

    //======================================================================
    // Stage 2: reduction to a canonical value below q
    //======================================================================
    assign rem_d = full_q % ntt_params_pkg::PRODUCT_W'(ntt_params_pkg::NTT_Q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid       <= 1'b0;
            lane.res_valid <= 1'b0;
        end else if (zeroize_i) begin
            s1_valid       <= 1'b0;
            lane.res_valid <= 1'b0;
        end else begin
            s1_valid       <= lane.valid;
            lane.res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        full_q   <= full_d;
        lane.res <= rem_d[ntt_params_pkg::COEFF_W-1:0];
    end

endmodule

/* logic/pwo_operand_split.sv */
// Operand feeder for the lane array.
// Registers the returned memory words and slices each into four
// 23-bit coefficients, one per lane.

module pwo_operand_split (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      data_valid_i,
    input  ntt_types_pkg::pwo_op_t    op_i,
    input  logic                      acc_i,
    input  ntt_types_pkg::mem_word_t  a_word_i,
    input  ntt_types_pkg::mem_word_t  b_word_i,
    input  ntt_types_pkg::mem_word_t  c_word_i,
    pwo_lane_if.feed                  lanes [ntt_params_pkg::LANES]
);

    logic                     valid_q;
    ntt_types_pkg::pwo_op_t   op_q;
    ntt_types_pkg::mem_word_t a_q;
    ntt_types_pkg::mem_word_t b_q;
    ntt_types_pkg::mem_word_t c_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else if (zeroize_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= data_valid_i;
        end
    end

    // Old destination only enters the sum when accumulating
    always_ff @(posedge clk) begin
        op_q <= op_i;
        a_q  <= a_word_i;
        b_q  <= b_word_i;
        c_q  <= (acc_i && op_i == ntt_types_pkg::PWO_MUL) ? c_word_i : '0;
    end

    // Pad bit of each slot is dropped here
    for (genvar g = 0; g < ntt_params_pkg::LANES; g++) begin : g_lane
        assign lanes[g].valid = valid_q;
        assign lanes[g].op    = op_q;
        assign lanes[g].a     = a_q[g][ntt_params_pkg::COEFF_W-1:0];
        assign lanes[g].b     = b_q[g][ntt_params_pkg::COEFF_W-1:0];
        assign lanes[g].c     = c_q[g][ntt_params_pkg::COEFF_W-1:0];
    end

endmodule

/* logic/pwo_ctrl.sv */
// Sequencer for one pointwise run over a 64-word polynomial.
// Latches the operation and base addresses on an enable pulse while
// idle, issues one read per cycle and reports busy and done.

module pwo_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      enable_i,
    input  ntt_types_pkg::pwo_op_t    mode_i,
    input  logic                      accumulate_i,
    input  ntt_types_pkg::mem_addr_t  a_base_i,
    input  ntt_types_pkg::mem_addr_t  b_base_i,
    input  ntt_types_pkg::mem_addr_t  c_base_i,
    output logic                      a_rd_en_o,
    output logic                      b_rd_en_o,
    output logic                      c_rd_en_o,
    output ntt_types_pkg::mem_addr_t  a_rd_addr_o,
    output ntt_types_pkg::mem_addr_t  b_rd_addr_o,
    output ntt_types_pkg::mem_addr_t  c_rd_addr_o,
    output logic                      data_valid_o,
    output ntt_types_pkg::pwo_op_t    op_o,
    output logic                      acc_o,
    input  logic                      last_write_i,
    output logic                      busy_o,
    output logic                      done_o
);

    logic [$clog2(ntt_params_pkg::POLY_WORDS)-1:0] rd_cnt;
    logic                     rd_active;
    logic                     start;
    ntt_types_pkg::mem_addr_t a_base_q;
    ntt_types_pkg::mem_addr_t b_base_q;
    ntt_types_pkg::mem_addr_t c_base_q;

    // Requests arriving mid-run or with no operation are dropped
    assign start = enable_i & ~busy_o & (mode_i != ntt_types_pkg::PWO_NONE);

    //======================================================================
    // Run state
    //======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o       <= 1'b0;
            done_o       <= 1'b0;
            rd_active    <= 1'b0;
            rd_cnt       <= '0;
            data_valid_o <= 1'b0;
            op_o         <= ntt_types_pkg::PWO_NONE;
            acc_o        <= 1'b0;
        end else if (zeroize_i) begin
            busy_o       <= 1'b0;
            done_o       <= 1'b0;
            rd_active    <= 1'b0;
            rd_cnt       <= '0;
            data_valid_o <= 1'b0;
            op_o         <= ntt_types_pkg::PWO_NONE;
            acc_o        <= 1'b0;
        end else begin
            // Memory answers one cycle after the request
            data_valid_o <= rd_active;
            done_o       <= busy_o & last_write_i;
            if (start) begin
                busy_o    <= 1'b1;
                rd_active <= 1'b1;
                rd_cnt    <= '0;
                op_o      <= mode_i;
                acc_o     <= accumulate_i;
            end else begin
                if (last_write_i) begin
                    busy_o <= 1'b0;
                end
                if (rd_active) begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == ($bits(rd_cnt))'(ntt_params_pkg::POLY_WORDS - 1)) begin
                        rd_active <= 1'b0;
                    end
                end
            end
        end
    end

    // Bases captured together with the operation at start
    always_ff @(posedge clk) begin
        if (start) begin
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
            c_base_q <= c_base_i;
        end
    end

    // Destination is only read for multiply-accumulate
    assign a_rd_en_o   = rd_active;
    assign b_rd_en_o   = rd_active;
    assign c_rd_en_o   = rd_active & acc_o & (op_o == ntt_types_pkg::PWO_MUL);
    assign a_rd_addr_o = a_base_q + ntt_types_pkg::mem_addr_t'(rd_cnt);
    assign b_rd_addr_o = b_base_q + ntt_types_pkg::mem_addr_t'(rd_cnt);
    assign c_rd_addr_o = c_base_q + ntt_types_pkg::mem_addr_t'(rd_cnt);

endmodule

/* logic/pwo_lane_if.sv */
// Per-lane connection of the pointwise datapath.
// The feeder drives operands, one modular lane computes, and the
// drainer collects the result. One instance exists per lane.

interface pwo_lane_if;

    // Operand side
    logic                  valid;
    ntt_types_pkg::pwo_op_t op;
    ntt_types_pkg::coeff_t a;
    ntt_types_pkg::coeff_t b;
    ntt_types_pkg::coeff_t c;

    // Result side
    logic                  res_valid;
    ntt_types_pkg::coeff_t res;

    modport feed (output valid, output op, output a, output b, output c);

    modport lane (
        input  valid, input  op, input  a, input  b, input  c,
        output res_valid, output res
    );

    modport drain (input res_valid, input res);

endinterface

/* logic/ntt_types_pkg.sv */
// Types shared by the pointwise datapath and its testbench.
// Holds the operation encoding and the coefficient, word and
// address types built on the numeric constants.

package ntt_types_pkg;

    // Pointwise operation select
    typedef enum logic [1:0] {
        PWO_MUL  = 2'b00,
        PWO_ADD  = 2'b01,
        PWO_SUB  = 2'b10,
        PWO_NONE = 2'b11
    } pwo_op_t;

    // One reduced coefficient
    typedef logic [ntt_params_pkg::COEFF_W-1:0] coeff_t;

    // Memory word, slot 0 in the low bits
    typedef logic [ntt_params_pkg::LANES-1:0][ntt_params_pkg::SLOT_W-1:0] mem_word_t;

    // Memory word address
    typedef logic [ntt_params_pkg::ADDR_W-1:0] mem_addr_t;

endpackage

/* logic/ntt_params_pkg.sv */
// Numeric constants for the pointwise datapath.
// Covers the lattice modulus, the memory word layout and the
// polynomial length. Referenced by scoped name from every other file.

package ntt_params_pkg;

    // Lattice modulus and coefficient width
    localparam int unsigned COEFF_W = 23;
    localparam logic [COEFF_W-1:0] NTT_Q = 23'd8380417;

    // One memory slot per coefficient, top bit is zero padding
    localparam int unsigned SLOT_W = 24;
    localparam int unsigned LANES = 4;
    localparam int unsigned WORD_W = LANES * SLOT_W;

    // 256 coefficients packed four to a word
    localparam int unsigned POLY_WORDS = 64;
    localparam int unsigned ADDR_W = 15;

    // Full 46-bit product plus one accumulate term
    localparam int unsigned PRODUCT_W = 47;

endpackage
